// File: axi_wdemux.f
src/axi_wdemux_pkg.sv
src/axi_wdemux_id_table.sv
src/axi_wdemux_aw_route.sv
src/axi_wdemux_w_route.sv
src/axi_wdemux_b_arbiter.sv
src/axi_wdemux_top.sv
tests/axi_wdemux_sva.sv
tests/tb_axi_wdemux.sv

// File: tests/tb_axi_wdemux.sv
/*
 * testbench for the AXI write demultiplexer
 * one master sends random writes, four slave models answer with
 * random ready, a monitor checks AW, W and B against the write list
 */

`timescale 1ns/1ps
`default_nettype none

module tb_axi_wdemux import axi_wdemux_pkg::*; ();

  localparam int NUM_WR     = 60;
  localparam int MAX_BEATS  = 2 ** LEN_W;
  localparam int WAIT_LIMIT = 2000;
  localparam int RUN_LIMIT  = 40000;

  logic clk_i;
  logic reset_i;
  aw_req_t slv_aw_i;
  logic slv_aw_valid_i;
  logic slv_aw_ready_o;
  w_chan_t slv_w_i;
  logic slv_w_valid_i;
  logic slv_w_ready_o;
  b_chan_t slv_b_o;
  logic slv_b_valid_o;
  logic slv_b_ready_i;
  aw_chan_t mst_aw_o;
  logic [NUM_PORTS-1:0] mst_aw_valid_o;
  logic [NUM_PORTS-1:0] mst_aw_ready_i;
  w_chan_t mst_w_o;
  logic [NUM_PORTS-1:0] mst_w_valid_o;
  logic [NUM_PORTS-1:0] mst_w_ready_i;
  b_chan_t [NUM_PORTS-1:0] mst_b_i;
  logic [NUM_PORTS-1:0] mst_b_valid_i;
  logic [NUM_PORTS-1:0] mst_b_ready_o;

  // --------------------
  // write list and scoreboard state
  // --------------------
  axi_id_t           wr_id   [NUM_WR];
  port_sel_t         wr_sel  [NUM_WR];
  logic [LEN_W-1:0]  wr_len  [NUM_WR];
  logic [ADDR_W-1:0] wr_addr [NUM_WR];
  logic              wr_gap  [NUM_WR];
  logic [DATA_W-1:0] wr_data [NUM_WR][MAX_BEATS];
  // write numbers per port in issue order
  int port_list [NUM_PORTS][NUM_WR];
  int port_cnt [NUM_PORTS];
  int aw_head [NUM_PORTS];
  int w_head [NUM_PORTS];
  int w_beat [NUM_PORTS];
  int b_head [NUM_PORTS];
  int b_drv [NUM_PORTS];
  // outstanding writes per id as seen from outside
  int out_cnt [NUM_IDS];
  int out_port [NUM_IDS];
  int aw_next;
  int b_done;
  int slv_b_cnt;
  int chk_cnt;
  int err_cnt;
  logic hung;
  logic [31:0] lfsr_q;

  axi_wdemux_top dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // reference response code for a write to a port
  function automatic logic [1:0] exp_resp(input int port, input axi_id_t id);
    return 2'((port + int'(id)) & 3);
  endfunction

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("[FAIL] %0t ns %s: got %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic build_writes();
    for (int j = 0; j < NUM_WR; j++) begin
      wr_id[j]   = ID_W'(rand_bits(ID_W));
      wr_sel[j]  = SEL_W'(rand_bits(SEL_W));
      wr_len[j]  = LEN_W'(rand_bits(LEN_W));
      wr_addr[j] = ADDR_W'(rand_bits(ADDR_W));
      wr_gap[j]  = rand_bits(1) != 0;
      for (int b = 0; b < MAX_BEATS; b++) begin
        wr_data[j][b] = DATA_W'(rand_bits(DATA_W));
      end
      port_list[wr_sel[j]][port_cnt[wr_sel[j]]] = j;
      port_cnt[wr_sel[j]]++;
    end
  endtask

  // --------------------
  // master side
  // --------------------
  task automatic send_aws();
    int t;
    for (int j = 0; j < NUM_WR; j++) begin
      @(negedge clk_i);
      if (wr_gap[j]) begin
        slv_aw_valid_i = 1'b0;
        @(negedge clk_i);
      end
      slv_aw_i.aw.id   = wr_id[j];
      slv_aw_i.aw.addr = wr_addr[j];
      slv_aw_i.aw.len  = wr_len[j];
      slv_aw_i.sel     = wr_sel[j];
      slv_aw_valid_i   = 1'b1;
      t = 0;
      do begin
        @(posedge clk_i);
        t++;
      end while (!slv_aw_ready_o && t < WAIT_LIMIT && !hung);
      if (!slv_aw_ready_o && t >= WAIT_LIMIT) begin
        $display("timeout: write %0d never accepted on the slave AW channel", j);
        err_cnt++;
        hung = 1'b1;
      end
      if (hung) return;
    end
    @(negedge clk_i);
    slv_aw_valid_i = 1'b0;
  endtask

  task automatic send_ws();
    int t;
    for (int j = 0; j < NUM_WR; j++) begin
      for (int b = 0; b <= int'(wr_len[j]); b++) begin
        @(negedge clk_i);
        if (wr_gap[j] && b == 0) begin
          slv_w_valid_i = 1'b0;
          @(negedge clk_i);
        end
        slv_w_i.data  = wr_data[j][b];
        slv_w_i.last  = (b == int'(wr_len[j]));
        slv_w_valid_i = 1'b1;
        t = 0;
        do begin
          @(posedge clk_i);
          t++;
        end while (!slv_w_ready_o && t < WAIT_LIMIT && !hung);
        if (!slv_w_ready_o && t >= WAIT_LIMIT) begin
          $display("timeout: beat %0d of write %0d never accepted on slave W", b, j);
          err_cnt++;
          hung = 1'b1;
        end
        if (hung) return;
      end
    end
    @(negedge clk_i);
    slv_w_valid_i = 1'b0;
  endtask

  // --------------------
  // slave models for all ports in one process
  // --------------------
  always @(negedge clk_i) begin
    int j;
    if (!reset_i) begin
      for (int p = 0; p < NUM_PORTS; p++) begin
        mst_aw_ready_i[p] = rand_bits(1) != 0;
        mst_w_ready_i[p]  = rand_bits(1) != 0;
        // drop B once the monitor saw it taken
        if (mst_b_valid_i[p] && b_head[p] > b_drv[p]) mst_b_valid_i[p] = 1'b0;
        // B only after both AW and the whole W burst arrived
        if (!mst_b_valid_i[p] && b_head[p] < w_head[p] && b_head[p] < aw_head[p]) begin
          if (rand_bits(1) != 0) begin
            j = port_list[p][b_head[p]];
            b_drv[p] = b_head[p];
            mst_b_i[p].id   = wr_id[j];
            mst_b_i[p].resp = exp_resp(p, wr_id[j]);
            mst_b_valid_i[p] = 1'b1;
          end
        end
      end
      slv_b_ready_i = rand_bits(1) != 0;
    end
  end

  // --------------------
  // compare process
  // --------------------
  always @(posedge clk_i) begin
    int j;
    if (!reset_i) begin
      // an id in flight stays on its port
      for (int p = 0; p < NUM_PORTS; p++) begin
        if (mst_aw_valid_o[p] && out_cnt[mst_aw_o.id] != 0)
          check_eq(32'(p), 32'(out_port[mst_aw_o.id]), "AW port while its id is in flight");
      end
      for (int p = 0; p < NUM_PORTS; p++) begin
        if (mst_aw_valid_o[p] && mst_aw_ready_i[p]) begin
          check_eq(32'(aw_next < NUM_WR), 32'd1, "AW expected");
          if (aw_next < NUM_WR) begin
            check_eq(32'(p), 32'(wr_sel[aw_next]), "AW port");
            check_eq(32'(mst_aw_o), 32'({wr_id[aw_next], wr_addr[aw_next], wr_len[aw_next]}),
                     "AW payload");
            out_cnt[mst_aw_o.id]++;
            out_port[mst_aw_o.id] = p;
            aw_next++;
            aw_head[p]++;
          end
        end
        if (mst_w_valid_o[p] && mst_w_ready_i[p]) begin
          check_eq(32'(w_head[p] < port_cnt[p]), 32'd1, "W beat expected on port");
          if (w_head[p] < port_cnt[p]) begin
            j = port_list[p][w_head[p]];
            check_eq(32'(mst_w_o),
                     32'({wr_data[j][w_beat[p]], w_beat[p] == int'(wr_len[j])}), "W beat");
            if (w_beat[p] == int'(wr_len[j])) begin
              w_head[p]++;
              w_beat[p] = 0;
            end else begin
              w_beat[p]++;
            end
          end
        end
        if (mst_b_valid_i[p] && mst_b_ready_o[p]) begin
          j = port_list[p][b_head[p]];
          check_eq(32'(slv_b_valid_o && slv_b_ready_i), 32'd1, "slave B taken with master B");
          check_eq(32'(slv_b_o), 32'({wr_id[j], exp_resp(p, wr_id[j])}), "B payload");
          b_head[p]++;
          b_done++;
        end
      end
      if (slv_b_valid_o && slv_b_ready_i) begin
        slv_b_cnt++;
        out_cnt[slv_b_o.id]--;
      end
    end
  end

  initial begin
    int t;
    reset_i        = 1'b1;
    slv_aw_i       = '0;
    slv_aw_valid_i = 1'b0;
    slv_w_i        = '0;
    slv_w_valid_i  = 1'b0;
    slv_b_ready_i  = 1'b0;
    mst_aw_ready_i = '0;
    mst_w_ready_i  = '0;
    mst_b_i        = '0;
    mst_b_valid_i  = '0;
    hung           = 1'b0;
    lfsr_q         = 32'h59d6_e04d;
    build_writes();
    repeat (10) @(negedge clk_i);
    reset_i <= 1'b0;
    // idle outputs before any traffic
    @(posedge clk_i);
    check_eq(32'(mst_aw_valid_o), 32'd0, "master AW valid after reset");
    check_eq(32'(mst_w_valid_o), 32'd0, "master W valid after reset");
    check_eq(32'(slv_b_valid_o), 32'd0, "slave B valid after reset");
    fork
      send_aws();
      send_ws();
    join_none
    t = 0;
    while (b_done < NUM_WR && !hung && t < RUN_LIMIT) begin
      @(negedge clk_i);
      t++;
    end
    if (b_done < NUM_WR && !hung) begin
      $display("timeout: only %0d of %0d write responses came back", b_done, NUM_WR);
      err_cnt++;
    end
    repeat (5) @(negedge clk_i);
    check_eq(32'(aw_next), 32'(NUM_WR), "AW count");
    check_eq(32'(slv_b_cnt), 32'(NUM_WR), "slave B count");
    for (int p = 0; p < NUM_PORTS; p++) begin
      check_eq(32'(w_head[p]), 32'(port_cnt[p]), "W bursts per port");
    end
    $display("checks: %0d  errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tests/axi_wdemux_sva.sv
/*
 * protocol assertions for the write demultiplexer
 * bound into the top level, checks that AW valid is one-hot and
 * follows a slave AW, and that held AW and B transfers stay stable
 */

`timescale 1ns/1ps
`default_nettype none

module axi_wdemux_sva import axi_wdemux_pkg::*; (
  input wire logic                 clk_i,
  input wire logic                 reset_i,
  input wire logic                 slv_aw_valid_i,
  input wire aw_chan_t             mst_aw_o,
  input wire logic [NUM_PORTS-1:0] mst_aw_valid_o,
  input wire logic [NUM_PORTS-1:0] mst_aw_ready_i,
  input wire b_chan_t              slv_b_o,
  input wire logic                 slv_b_valid_o,
  input wire logic                 slv_b_ready_i
);

  // at most one port sees an AW and only while the slave offers one
  a_aw_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
    |mst_aw_valid_o |-> $onehot0(mst_aw_valid_o) && slv_aw_valid_i)
    else $error("master AW valid on more than one port or without a slave AW");

  // stalled response keeps valid and payload
  a_b_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    slv_b_valid_o && !slv_b_ready_i |=> slv_b_valid_o && $stable(slv_b_o))
    else $error("slave B dropped or changed under back-pressure");

  // --------------------
  // per-port AW hold
  // --------------------
  for (genvar i = 0; i < NUM_PORTS; i++) begin : g_aw_hold
    a_aw_stable: assert property (@(posedge clk_i) disable iff (reset_i)
      mst_aw_valid_o[i] && !mst_aw_ready_i[i] |=> mst_aw_valid_o[i] && $stable(mst_aw_o))
      else $error("master AW on port %0d dropped or changed before ready", i);
  end

endmodule

bind axi_wdemux_top axi_wdemux_sva u_sva (.*);

`default_nettype wire

// File: src/axi_wdemux_top.sv
/*
 * AXI write demultiplexer, top level
 * one slave port to four master ports, AW routed by a requester
 * select, W following in order, B merged round-robin
 */

`timescale 1ns/1ps
`default_nettype none

module axi_wdemux_top import axi_wdemux_pkg::*; (
  input  wire logic                    clk_i,
  input  wire logic                    reset_i,
  // slave port
  input  wire aw_req_t                 slv_aw_i,
  input  wire logic                    slv_aw_valid_i,
  output logic                         slv_aw_ready_o,
  input  wire w_chan_t                 slv_w_i,
  input  wire logic                    slv_w_valid_i,
  output logic                         slv_w_ready_o,
  output b_chan_t                      slv_b_o,
  output logic                         slv_b_valid_o,
  input  wire logic                    slv_b_ready_i,
  // master ports
  output aw_chan_t                     mst_aw_o,
  output logic    [NUM_PORTS-1:0]      mst_aw_valid_o,
  input  wire logic [NUM_PORTS-1:0]    mst_aw_ready_i,
  output w_chan_t                      mst_w_o,
  output logic    [NUM_PORTS-1:0]      mst_w_valid_o,
  input  wire logic [NUM_PORTS-1:0]    mst_w_ready_i,
  input  wire b_chan_t [NUM_PORTS-1:0] mst_b_i,
  input  wire logic [NUM_PORTS-1:0]    mst_b_valid_i,
  output logic    [NUM_PORTS-1:0]      mst_b_ready_o
);

  port_sel_t lookup_sel;
  logic      occupied;
  logic      id_full;
  logic      w_fifo_full;
  logic      push;
  logic      pop;
  axi_id_t   pop_id;

  // --------------------
  // write bookkeeping
  // --------------------
  axi_wdemux_id_table u_id_table (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .lookup_id_i  (slv_aw_i.aw.id),
    .lookup_sel_o (lookup_sel),
    .occupied_o   (occupied),
    .full_o       (id_full),
    .push_i       (push),
    .push_id_i    (slv_aw_i.aw.id),
    .push_sel_i   (slv_aw_i.sel),
    .pop_i        (pop),
    .pop_id_i     (pop_id)
  );

  axi_wdemux_aw_route u_aw_route (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .slv_aw_i       (slv_aw_i),
    .slv_aw_valid_i (slv_aw_valid_i),
    .slv_aw_ready_o (slv_aw_ready_o),
    .mst_aw_o       (mst_aw_o),
    .mst_aw_valid_o (mst_aw_valid_o),
    .mst_aw_ready_i (mst_aw_ready_i),
    .lookup_sel_i   (lookup_sel),
    .occupied_i     (occupied),
    .id_full_i      (id_full),
    .w_fifo_full_i  (w_fifo_full),
    .push_o         (push)
  );

  // W order follows AW admission order
  axi_wdemux_w_route u_w_route (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .push_i        (push),
    .push_sel_i    (slv_aw_i.sel),
    .full_o        (w_fifo_full),
    .slv_w_i       (slv_w_i),
    .slv_w_valid_i (slv_w_valid_i),
    .slv_w_ready_o (slv_w_ready_o),
    .mst_w_o       (mst_w_o),
    .mst_w_valid_o (mst_w_valid_o),
    .mst_w_ready_i (mst_w_ready_i)
  );

  axi_wdemux_b_arbiter u_b_arbiter (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .mst_b_i       (mst_b_i),
    .mst_b_valid_i (mst_b_valid_i),
    .mst_b_ready_o (mst_b_ready_o),
    .slv_b_o       (slv_b_o),
    .slv_b_valid_o (slv_b_valid_o),
    .slv_b_ready_i (slv_b_ready_i),
    .pop_o         (pop),
    .pop_id_o      (pop_id)
  );

endmodule

`default_nettype wire

// File: src/axi_wdemux_b_arbiter.sv
/*
 * B response arbiter
 * round-robin merge of the master B channels onto the slave port
 * grant is held while the slave stalls, pointer moves on after a transfer
 */

`timescale 1ns/1ps
`default_nettype none

module axi_wdemux_b_arbiter import axi_wdemux_pkg::*; (
  input  wire logic                        clk_i,
  input  wire logic                        reset_i,
  // master B
  input  wire b_chan_t [NUM_PORTS-1:0]     mst_b_i,
  input  wire logic    [NUM_PORTS-1:0]     mst_b_valid_i,
  output logic         [NUM_PORTS-1:0]     mst_b_ready_o,
  // slave B
  output b_chan_t                          slv_b_o,
  output logic                             slv_b_valid_o,
  input  wire logic                        slv_b_ready_i,
  // completed response to the ID table
  output logic                             pop_o,
  output axi_id_t                          pop_id_o
);

  // highest priority port
  port_sel_t rr_q;
  logic      lock_q;
  port_sel_t lock_idx_q;

  port_sel_t pick;
  port_sel_t cand;
  port_sel_t gnt_idx;

  // --------------------
  // round-robin search
  // --------------------
  always_comb begin
    pick = rr_q;
    for (int i = NUM_PORTS - 1; i >= 0; i--) begin
      // walking down leaves the last hit closest to the pointer
      cand = port_sel_t'(rr_q + i);
      if (mst_b_valid_i[cand]) pick = cand;
    end
  end

  // held grant overrides the search
  assign gnt_idx       = lock_q ? lock_idx_q : pick;
  assign slv_b_o       = mst_b_i[gnt_idx];
  assign slv_b_valid_o = mst_b_valid_i[gnt_idx];

  always_comb begin
    mst_b_ready_o = '0;
    mst_b_ready_o[gnt_idx] = slv_b_valid_o && slv_b_ready_i;
  end

  assign pop_o    = slv_b_valid_o && slv_b_ready_i;
  assign pop_id_o = slv_b_o.id;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rr_q       <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else begin
      // back-pressure keeps the current winner
      lock_q     <= slv_b_valid_o && !slv_b_ready_i;
      lock_idx_q <= gnt_idx;
      if (pop_o) rr_q <= gnt_idx + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: src/axi_wdemux_w_route.sv
/*
 * W router
 * circular FIFO of port selects, one entry per admitted write
 * the head entry steers the W beats of one burst to its port
 * and is dropped on the transfer of the last beat
 */

`timescale 1ns/1ps
`default_nettype none

module axi_wdemux_w_route import axi_wdemux_pkg::*; (
  input  wire logic                 clk_i,
  input  wire logic                 reset_i,
  // select push from the AW side
  input  wire logic                 push_i,
  input  wire port_sel_t            push_sel_i,
  output logic                      full_o,
  // slave W
  input  wire w_chan_t              slv_w_i,
  input  wire logic                 slv_w_valid_i,
  output logic                      slv_w_ready_o,
  // master W, payload broadcast
  output w_chan_t                   mst_w_o,
  output logic     [NUM_PORTS-1:0]  mst_w_valid_o,
  input  wire logic [NUM_PORTS-1:0] mst_w_ready_i
);

  // select storage
  port_sel_t [W_FIFO_DEPTH-1:0] sel_mem;

  logic [$clog2(W_FIFO_DEPTH)-1:0]   wr_ptr_q;
  logic [$clog2(W_FIFO_DEPTH)-1:0]   rd_ptr_q;
  logic [$clog2(W_FIFO_DEPTH+1)-1:0] count_q;

  logic      empty;
  logic      pop;
  port_sel_t head_sel;

  assign empty    = (count_q == '0);
  assign full_o   = (count_q == W_FIFO_DEPTH);
  assign head_sel = sel_mem[rd_ptr_q];

  // --------------------
  // beat steering
  // --------------------
  assign mst_w_o = slv_w_i;

  always_comb begin
    mst_w_valid_o = '0;
    // no burst announced yet means W stalls
    mst_w_valid_o[head_sel] = slv_w_valid_i && !empty;
  end

  assign slv_w_ready_o = !empty && mst_w_ready_i[head_sel];

  // burst done on last beat handshake
  assign pop = slv_w_valid_i && slv_w_ready_o && slv_w_i.last;

  // --------------------
  // FIFO pointers
  // --------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      // pointers wrap by themselves since the depth is a power of two
      if (push_i) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop) rd_ptr_q <= rd_ptr_q + 1'b1;
      if (push_i && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push_i) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) sel_mem[wr_ptr_q] <= push_sel_i;
  end

endmodule

`default_nettype wire

// File: src/axi_wdemux_aw_route.sv
/*
 * AW router
 * admits a slave AW when the ID table and W FIFO allow it and
 * forwards it to the selected master port in the same cycle
 * a lock register keeps the master valid up until the handshake
 */

`timescale 1ns/1ps
`default_nettype none

module axi_wdemux_aw_route import axi_wdemux_pkg::*; (
  input  wire logic                 clk_i,
  input  wire logic                 reset_i,
  // slave AW
  input  wire aw_req_t              slv_aw_i,
  input  wire logic                 slv_aw_valid_i,
  output logic                      slv_aw_ready_o,
  // master AW, payload broadcast
  output aw_chan_t                  mst_aw_o,
  output logic     [NUM_PORTS-1:0]  mst_aw_valid_o,
  input  wire logic [NUM_PORTS-1:0] mst_aw_ready_i,
  // ID table and W FIFO status
  input  wire port_sel_t            lookup_sel_i,
  input  wire logic                 occupied_i,
  input  wire logic                 id_full_i,
  input  wire logic                 w_fifo_full_i,
  output logic                      push_o
);

  logic lock_q;
  logic lock_d;
  logic aw_valid;
  logic aw_ready;
  logic admit;

  // ready of the selected port only
  assign aw_ready = mst_aw_ready_i[slv_aw_i.sel];

  // id free or already in flight to this same port
  assign admit = slv_aw_valid_i && !id_full_i && !w_fifo_full_i &&
                 (!occupied_i || (lookup_sel_i == slv_aw_i.sel));

  // --------------------
  // handshake control
  // --------------------
  always_comb begin
    aw_valid       = 1'b0;
    slv_aw_ready_o = 1'b0;
    push_o         = 1'b0;
    lock_d         = lock_q;
    if (lock_q) begin
      // decision already taken and pushed so only wait for ready
      aw_valid = 1'b1;
      if (aw_ready) begin
        slv_aw_ready_o = 1'b1;
        lock_d         = 1'b0;
      end
    end else if (admit) begin
      aw_valid = 1'b1;
      // push once on first assertion
      push_o   = 1'b1;
      if (aw_ready) begin
        slv_aw_ready_o = 1'b1;
      end else begin
        lock_d = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      lock_q <= 1'b0;
    end else begin
      lock_q <= lock_d;
    end
  end

  // --------------------
  // master side
  // --------------------
  assign mst_aw_o = slv_aw_i.aw;

  // one-hot valid on the selected port
  always_comb begin
    mst_aw_valid_o = '0;
    mst_aw_valid_o[slv_aw_i.sel] = aw_valid;
  end

endmodule

`default_nettype wire

// File: src/axi_wdemux_id_table.sv
/*
 * write ID table
 * one in-flight counter per AXI ID plus the port the ID last went to
 * lookup is combinational, push and pop update the counters
 * full goes high as soon as any counter saturates
 */

`timescale 1ns/1ps
`default_nettype none

module axi_wdemux_id_table import axi_wdemux_pkg::*; (
  input  wire logic      clk_i,
  input  wire logic      reset_i,
  // lookup for the AW waiting at the slave port
  input  wire axi_id_t   lookup_id_i,
  output port_sel_t      lookup_sel_o,
  output logic           occupied_o,
  output logic           full_o,
  // new write admitted
  input  wire logic      push_i,
  input  wire axi_id_t   push_id_i,
  input  wire port_sel_t push_sel_i,
  // response handed back to the slave port
  input  wire logic      pop_i,
  input  wire axi_id_t   pop_id_i
);

  // in-flight count per id
  logic      [NUM_IDS-1:0][CNT_W-1:0] cnt_q;
  // port of the writes in flight per id
  port_sel_t [NUM_IDS-1:0]            sel_q;

  logic [NUM_IDS-1:0] push_en;
  logic [NUM_IDS-1:0] pop_en;
  logic [NUM_IDS-1:0] cnt_full;

  // --------------------
  // lookup
  // --------------------
  assign lookup_sel_o = sel_q[lookup_id_i];
  assign occupied_o   = |cnt_q[lookup_id_i];

  // one-hot decode of the push and pop ids
  assign push_en = push_i ? (NUM_IDS'(1) << push_id_i) : '0;
  assign pop_en  = pop_i  ? (NUM_IDS'(1) << pop_id_i)  : '0;

  always_comb begin
    for (int i = 0; i < NUM_IDS; i++) begin
      cnt_full[i] = &cnt_q[i];
    end
  end

  // any saturated counter stops all admissions
  assign full_o = |cnt_full;

  // --------------------
  // counters
  // --------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cnt_q <= '0;
    end else begin
      for (int i = 0; i < NUM_IDS; i++) begin
        // push together with pop on the same id leaves the count
        if (push_en[i] && !pop_en[i]) begin
          cnt_q[i] <= cnt_q[i] + 1'b1;
        end else if (pop_en[i] && !push_en[i]) begin
          cnt_q[i] <= cnt_q[i] - 1'b1;
        end
      end
    end
  end

  // remembered port is only meaningful while the counter is nonzero
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < NUM_IDS; i++) begin
      if (push_en[i]) begin
        sel_q[i] <= push_sel_i;
      end
    end
  end

endmodule

`default_nettype wire

// File: src/axi_wdemux_pkg.sv
/*
 * AXI write demultiplexer package
 * shared widths, port count, buffer depths and the channel
 * structs used on the slave port, the master ports and inside
 */

`default_nettype none

package axi_wdemux_pkg;

  // --------------------
  // sizes
  // --------------------
  localparam int unsigned NUM_PORTS    = 4;
  localparam int unsigned SEL_W        = 2;
  localparam int unsigned ID_W         = 3;
  localparam int unsigned NUM_IDS      = 8;
  // a counter at all ones counts as full
  localparam int unsigned CNT_W        = 3;
  localparam int unsigned W_FIFO_DEPTH = 8;
  localparam int unsigned ADDR_W       = 16;
  localparam int unsigned DATA_W       = 16;
  localparam int unsigned LEN_W        = 4;

  typedef logic [SEL_W-1:0] port_sel_t;
  typedef logic [ID_W-1:0]  axi_id_t;

  // --------------------
  // channel payloads
  // --------------------
  // len is beats minus one
  typedef struct packed {
    axi_id_t           id;
    logic [ADDR_W-1:0] addr;
    logic [LEN_W-1:0]  len;
  } aw_chan_t;

  // aw as issued by the requester, with its target port
  typedef struct packed {
    aw_chan_t  aw;
    port_sel_t sel;
  } aw_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic              last;
  } w_chan_t;

  typedef struct packed {
    axi_id_t    id;
    logic [1:0] resp;
  } b_chan_t;

endpackage

`default_nettype wire
